//--- design/obi_pkg.sv
/*
 * OBI slave port definitions
 * Bus widths and the word types carried on request and response
 */
`default_nettype none

package obi_pkg;

  // Byte address and data widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // One enable per byte lane
  localparam int unsigned BE_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;

endpackage

`default_nettype wire

//--- design/harness_pkg.sv
/*
 * Harness constants
 * Power-domain counts, switch latency and slow memory sizing
 */
`default_nettype none

package harness_pkg;

  // Switch cell emulation
  localparam int unsigned SWITCH_ACK_LATENCY = 15;
  localparam int unsigned NUM_BANKS          = 4;
  localparam int unsigned EXT_DOMAINS        = 2;

  // Slow memory and its request buffer
  localparam int unsigned MEM_WORDS  = 1024;
  localparam int unsigned MEM_WAIT   = 2;
  localparam int unsigned FIFO_DEPTH = 2;

  // One switch bit per bank or domain, active low
  typedef logic [NUM_BANKS-1:0]   bank_sw_t;
  typedef logic [EXT_DOMAINS-1:0] ext_sw_t;

endpackage

`default_nettype wire

//--- design/switch_ack_delay.sv
/*
 * Power switch cell emulation
 * Acknowledge follows the switch request after a fixed number of cycles
 */
`timescale 1ns/1ns
`default_nettype none

module switch_ack_delay #(
  parameter type payload_t = logic
) (
  input  wire      clk_i,
  input  wire      rst_n_i,
  input  payload_t switch_n_i,
  output payload_t switch_ack_n_o
);

  localparam int unsigned LAT = harness_pkg::SWITCH_ACK_LATENCY;

  payload_t stage_q [LAT];

  // Switches come up open, so every stage resets to ones
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < LAT; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < LAT; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = stage_q[LAT-1];

  // Exact latency once the line has been filled since reset
  a_ack_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i, LAT) |-> switch_ack_n_o == $past(switch_n_i, LAT));

endmodule

`default_nettype wire

//--- design/obi_req_fifo.sv
/*
 * OBI request buffer
 * Holds taken requests in order until the slow memory grants them
 */
`timescale 1ns/1ns
`default_nettype none

module obi_req_fifo (
  input  wire             clk_i,
  input  wire             rst_n_i,
  // Producer side
  input  logic            req_i,
  input  logic            we_i,
  input  obi_pkg::be_t    be_i,
  input  obi_pkg::addr_t  addr_i,
  input  obi_pkg::data_t  wdata_i,
  output logic            gnt_o,
  // Memory side
  output logic            mem_req_o,
  output logic            mem_we_o,
  output obi_pkg::be_t    mem_be_o,
  output obi_pkg::addr_t  mem_addr_o,
  output obi_pkg::data_t  mem_wdata_o,
  input  logic            mem_gnt_i
);

  localparam int unsigned DEPTH = harness_pkg::FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef struct packed {
    logic           we;
    obi_pkg::be_t   be;
    obi_pkg::addr_t addr;
    obi_pkg::data_t wdata;
  } entry_t;

  entry_t           buf_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;
  entry_t           head;

  // Accept whenever there is room
  assign gnt_o = (count_q != CNT_W'(DEPTH));
  assign push  = req_i & gnt_o;
  assign pop   = mem_gnt_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[wr_ptr_q] <= '{we: we_i, be: be_i, addr: addr_i, wdata: wdata_i};
    end
  end

  // Oldest entry faces the memory
  assign head        = buf_q[rd_ptr_q];
  assign mem_req_o   = (count_q != '0);
  assign mem_we_o    = head.we;
  assign mem_be_o    = head.be;
  assign mem_addr_o  = head.addr;
  assign mem_wdata_o = head.wdata;

  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_gnt_i |-> mem_req_o);

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- design/slow_memory.sv
/*
 * Slow word memory
 * Grants after wait states, writes enabled bytes, answers one cycle later
 */
`timescale 1ns/1ns
`default_nettype none

module slow_memory (
  input  wire             clk_i,
  input  wire             rst_n_i,
  input  logic            req_i,
  input  logic            we_i,
  input  obi_pkg::be_t    be_i,
  input  obi_pkg::addr_t  addr_i,
  input  obi_pkg::data_t  wdata_i,
  output logic            gnt_o,
  output logic            rvalid_o,
  output obi_pkg::data_t  rdata_o
);

  localparam int unsigned WORDS  = harness_pkg::MEM_WORDS;
  localparam int unsigned WAIT   = harness_pkg::MEM_WAIT;
  localparam int unsigned IDX_W  = $clog2(WORDS);
  localparam int unsigned OFF_W  = $clog2(obi_pkg::BE_W);
  localparam int unsigned WAIT_W = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

  obi_pkg::data_t    mem_q [WORDS];
  obi_pkg::data_t    rdata_q;
  logic              rvalid_q;
  logic [WAIT_W-1:0] wait_q;
  logic [IDX_W-1:0]  idx;

  // Word index drops the byte offset and wraps at the memory size
  assign idx = addr_i[OFF_W +: IDX_W];

  // Grant once the request has waited long enough
  assign gnt_o = req_i && (wait_q == WAIT_W'(WAIT));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_q   <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt_o;
      if (!req_i || gnt_o) begin
        wait_q <= '0;
      end else begin
        wait_q <= wait_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (we_i) begin
        for (int b = 0; b < obi_pkg::BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  // Response only after a grant to a request held through the wait states
  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o |-> $past(gnt_o) && $past(req_i, WAIT + 1));

endmodule

`default_nettype wire

//--- design/ext_harness_top.sv
/*
 * External harness top
 * Switch cell emulators and the buffered slow memory behind an OBI port
 */
`timescale 1ns/1ns
`default_nettype none

module ext_harness_top (
  input  wire                   clk_i,
  input  wire                   rst_n_i,
  // Switch requests
  input  logic                  cpu_switch_n_i,
  input  logic                  periph_switch_n_i,
  input  harness_pkg::bank_sw_t banks_switch_n_i,
  input  harness_pkg::ext_sw_t  ext_switch_n_i,
  // Switch acknowledges
  output logic                  cpu_switch_ack_n_o,
  output logic                  periph_switch_ack_n_o,
  output harness_pkg::bank_sw_t banks_switch_ack_n_o,
  output harness_pkg::ext_sw_t  ext_switch_ack_n_o,
  // OBI request
  input  logic                  req_i,
  input  logic                  we_i,
  input  obi_pkg::be_t          be_i,
  input  obi_pkg::addr_t        addr_i,
  input  obi_pkg::data_t        wdata_i,
  // OBI response
  output logic                  gnt_o,
  output logic                  rvalid_o,
  output obi_pkg::data_t        rdata_o
);

  logic           mem_req;
  logic           mem_we;
  obi_pkg::be_t   mem_be;
  obi_pkg::addr_t mem_addr;
  obi_pkg::data_t mem_wdata;
  logic           mem_gnt;

  // One switch emulator per domain group
  switch_ack_delay #(.payload_t(logic)) u_cpu_sw (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .switch_n_i     (cpu_switch_n_i),
    .switch_ack_n_o (cpu_switch_ack_n_o)
  );

  switch_ack_delay #(.payload_t(logic)) u_periph_sw (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .switch_n_i     (periph_switch_n_i),
    .switch_ack_n_o (periph_switch_ack_n_o)
  );

  switch_ack_delay #(.payload_t(harness_pkg::bank_sw_t)) u_banks_sw (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .switch_n_i     (banks_switch_n_i),
    .switch_ack_n_o (banks_switch_ack_n_o)
  );

  switch_ack_delay #(.payload_t(harness_pkg::ext_sw_t)) u_ext_sw (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .switch_n_i     (ext_switch_n_i),
    .switch_ack_n_o (ext_switch_ack_n_o)
  );

  // Buffer adds latency in front of the already slow memory
  obi_req_fifo u_req_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .be_i        (be_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .gnt_o       (gnt_o),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_be_o    (mem_be),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_gnt_i   (mem_gnt)
  );

  slow_memory u_slow_ram (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .be_i     (mem_be),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .gnt_o    (mem_gnt),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o)
  );

endmodule

`default_nettype wire

//--- dv/tb_ext_harness.sv
/*
 * Testbench for the external harness top
 * Random switch and OBI traffic checked against reference models
 */
`timescale 1ns/1ns
`default_nettype none

module tb_ext_harness;

  localparam int unsigned SEED          = 96;
  localparam int          LAT           = int'(harness_pkg::SWITCH_ACK_LATENCY);
  localparam int          DEPTH         = int'(harness_pkg::FIFO_DEPTH);
  localparam int          MAX_INFLIGHT  = DEPTH + 1;
  localparam int          N_WRITES      = 300;
  localparam int          N_READS       = 200;
  localparam int          N_MIXED       = 400;
  localparam int          TOTAL_OPS     = int'(harness_pkg::MEM_WORDS) + N_WRITES + N_READS
                                          + N_MIXED;
  localparam int          GNT_TIMEOUT   = 50;
  localparam int          DRAIN_TIMEOUT = 200;

  logic                  clk_i = 1'b0;
  logic                  rst_n_i;
  logic                  cpu_switch_n_i;
  logic                  periph_switch_n_i;
  harness_pkg::bank_sw_t banks_switch_n_i;
  harness_pkg::ext_sw_t  ext_switch_n_i;
  logic                  cpu_switch_ack_n_o;
  logic                  periph_switch_ack_n_o;
  harness_pkg::bank_sw_t banks_switch_ack_n_o;
  harness_pkg::ext_sw_t  ext_switch_ack_n_o;
  logic                  req_i;
  logic                  we_i;
  obi_pkg::be_t          be_i;
  obi_pkg::addr_t        addr_i;
  obi_pkg::data_t        wdata_i;
  logic                  gnt_o;
  logic                  rvalid_o;
  obi_pkg::data_t        rdata_o;

  // Reference state
  logic                  cpu_hist [$];
  logic                  periph_hist [$];
  harness_pkg::bank_sw_t bank_hist [$];
  harness_pkg::ext_sw_t  ext_hist [$];
  obi_pkg::data_t        model_mem [harness_pkg::MEM_WORDS];
  logic                  exp_is_read [$];
  obi_pkg::data_t        exp_data [$];
  int                    taken_count = 0;
  int                    rvalid_count = 0;
  logic                  switches_on = 1'b0;

  ext_harness_top dut0 (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .cpu_switch_n_i        (cpu_switch_n_i),
    .periph_switch_n_i     (periph_switch_n_i),
    .banks_switch_n_i      (banks_switch_n_i),
    .ext_switch_n_i        (ext_switch_n_i),
    .cpu_switch_ack_n_o    (cpu_switch_ack_n_o),
    .periph_switch_ack_n_o (periph_switch_ack_n_o),
    .banks_switch_ack_n_o  (banks_switch_ack_n_o),
    .ext_switch_ack_n_o    (ext_switch_ack_n_o),
    .req_i                 (req_i),
    .we_i                  (we_i),
    .be_i                  (be_i),
    .addr_i                (addr_i),
    .wdata_i               (wdata_i),
    .gnt_o                 (gnt_o),
    .rvalid_o              (rvalid_o),
    .rdata_o               (rdata_o)
  );

  always #5 clk_i = ~clk_i;

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_ack_bit(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      fail_now($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, act, exp));
    end
  endtask

  task automatic check_ack_banks(input harness_pkg::bank_sw_t act,
                                 input harness_pkg::bank_sw_t exp);
    if (act !== exp) begin
      fail_now($sformatf("MISMATCH at %0t: banks_switch_ack_n_o is %b, expected %b",
                         $time, act, exp));
    end
  endtask

  task automatic check_ack_ext(input harness_pkg::ext_sw_t act,
                               input harness_pkg::ext_sw_t exp);
    if (act !== exp) begin
      fail_now($sformatf("MISMATCH at %0t: ext_switch_ack_n_o is %b, expected %b",
                         $time, act, exp));
    end
  endtask

  task automatic check_flag(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      fail_now($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, act, exp));
    end
  endtask

  task automatic check_rdata(input obi_pkg::data_t act, input obi_pkg::data_t exp);
    if (act !== exp) begin
      fail_now($sformatf("MISMATCH at %0t: rdata_o is %08h, expected %08h", $time, act, exp));
    end
  endtask

  task automatic check_count(input int act, input int exp, input string what);
    if (act != exp) begin
      fail_now($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, act, exp));
    end
  endtask

  function automatic obi_pkg::data_t merge_bytes(input obi_pkg::data_t old_word,
                                                 input obi_pkg::data_t new_word,
                                                 input obi_pkg::be_t   be);
    obi_pkg::data_t res;
    res = old_word;
    for (int b = 0; b < int'(obi_pkg::BE_W); b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // Initial content, different for every word address
  function automatic obi_pkg::data_t fill_word(input int unsigned idx);
    return obi_pkg::data_t'(idx * 32'h9E37_79B1) ^ 32'hC3A5_0000;
  endfunction

  // Presents one request and returns on the edge that takes it
  task automatic issue(input logic we, input obi_pkg::be_t be, input obi_pkg::addr_t addr,
                       input obi_pkg::data_t wdata);
    int waited;
    waited = 0;
    req_i   <= 1'b1;
    we_i    <= we;
    be_i    <= be;
    addr_i  <= addr;
    wdata_i <= wdata;
    @(negedge clk_i);
    while (gnt_o !== 1'b1 && waited < GNT_TIMEOUT) begin
      waited++;
      @(negedge clk_i);
    end
    if (gnt_o !== 1'b1) begin
      fail_now("ERROR: timed out waiting for gnt_o on a pending request");
    end
    @(posedge clk_i);
  endtask

  task automatic random_op(input logic we);
    int unsigned idx;
    idx = $urandom_range(harness_pkg::MEM_WORDS - 1, 0);
    issue(we, obi_pkg::be_t'($urandom()), obi_pkg::addr_t'(idx << 2),
          obi_pkg::data_t'($urandom()));
  endtask

  // Every request sent by the sequence must come back with one rvalid pulse
  task automatic drain();
    int waited;
    waited = 0;
    while (rvalid_count < TOTAL_OPS && waited < DRAIN_TIMEOUT) begin
      waited++;
      @(negedge clk_i);
    end
    if (rvalid_count < TOTAL_OPS) begin
      fail_now("ERROR: timed out waiting for rvalid_o on outstanding requests");
    end
  endtask

  always @(posedge clk_i) begin
    if (switches_on) begin
      cpu_switch_n_i    <= 1'($urandom());
      periph_switch_n_i <= 1'($urandom());
      banks_switch_n_i  <= harness_pkg::bank_sw_t'($urandom());
      ext_switch_n_i    <= harness_pkg::ext_sw_t'($urandom());
    end
  end

  // Each acknowledge is the request seen LAT edges before
  always @(negedge clk_i) begin : switch_monitor
    if (rst_n_i === 1'b1) begin
      check_ack_bit(cpu_switch_ack_n_o, cpu_hist.pop_front(), "cpu_switch_ack_n_o");
      check_ack_bit(periph_switch_ack_n_o, periph_hist.pop_front(), "periph_switch_ack_n_o");
      check_ack_banks(banks_switch_ack_n_o, bank_hist.pop_front());
      check_ack_ext(ext_switch_ack_n_o, ext_hist.pop_front());
      cpu_hist.push_back(cpu_switch_n_i);
      periph_hist.push_back(periph_switch_n_i);
      bank_hist.push_back(banks_switch_n_i);
      ext_hist.push_back(ext_switch_n_i);
    end
  end

  always @(negedge clk_i) begin : obi_monitor
    int          inflight;
    int          pending;
    int unsigned widx;
    logic        is_read;
    obi_pkg::data_t data;
    if (rst_n_i === 1'b1) begin
      inflight = exp_is_read.size();
      if (inflight > MAX_INFLIGHT) begin
        fail_now("ERROR: more requests in flight than the buffer and memory can hold");
      end
      if (rvalid_o === 1'b1) begin
        if (inflight == 0) begin
          fail_now("ERROR: rvalid_o pulsed with no request outstanding");
        end
        is_read = exp_is_read.pop_front();
        data    = exp_data.pop_front();
        rvalid_count++;
        if (is_read) begin
          check_rdata(rdata_o, data);
        end
      end
      // Requests not yet granted by the memory sit in the buffer
      pending = exp_is_read.size();
      check_flag(gnt_o, pending != DEPTH, "gnt_o");
      if (req_i === 1'b1 && gnt_o === 1'b1) begin
        widx = (addr_i >> 2) % harness_pkg::MEM_WORDS;
        taken_count++;
        if (we_i) begin
          model_mem[widx] = merge_bytes(model_mem[widx], wdata_i, be_i);
          exp_is_read.push_back(1'b0);
          exp_data.push_back('0);
        end else begin
          exp_is_read.push_back(1'b1);
          exp_data.push_back(model_mem[widx]);
        end
      end
    end
  end

  initial begin : main_seq
    int gap;
    void'($urandom(SEED));
    rst_n_i           = 1'b0;
    cpu_switch_n_i    = 1'b1;
    periph_switch_n_i = 1'b1;
    banks_switch_n_i  = '1;
    ext_switch_n_i    = '1;
    req_i             = 1'b0;
    we_i              = 1'b0;
    be_i              = '0;
    addr_i            = '0;
    wdata_i           = '0;
    for (int i = 0; i < LAT; i++) begin
      cpu_hist.push_back(1'b1);
      periph_hist.push_back(1'b1);
      bank_hist.push_back('1);
      ext_hist.push_back('1);
    end

    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_ack_bit(cpu_switch_ack_n_o, 1'b1, "cpu_switch_ack_n_o after reset");
    check_ack_bit(periph_switch_ack_n_o, 1'b1, "periph_switch_ack_n_o after reset");
    check_ack_banks(banks_switch_ack_n_o, '1);
    check_ack_ext(ext_switch_ack_n_o, '1);
    check_flag(gnt_o, 1'b1, "gnt_o after reset");
    check_flag(rvalid_o, 1'b0, "rvalid_o after reset");
    switches_on = 1'b1;
    @(posedge clk_i);

    // Whole memory gets known content first
    for (int unsigned idx = 0; idx < harness_pkg::MEM_WORDS; idx++) begin
      issue(1'b1, '1, obi_pkg::addr_t'(idx << 2), fill_word(idx));
    end

    for (int i = 0; i < N_WRITES; i++) begin
      random_op(1'b1);
      gap = $urandom_range(2, 0);
      if (gap > 0) begin
        req_i <= 1'b0;
        repeat (gap) @(posedge clk_i);
      end
    end
    for (int i = 0; i < N_READS; i++) begin
      random_op(1'b0);
    end
    for (int i = 0; i < N_MIXED; i++) begin
      random_op(1'($urandom()));
    end
    req_i <= 1'b0;

    drain();
    repeat (20) @(negedge clk_i);
    check_count(rvalid_count, taken_count, "rvalid pulse count");
    check_count(exp_is_read.size(), 0, "outstanding requests");
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
design/obi_pkg.sv
design/harness_pkg.sv
design/switch_ack_delay.sv
design/obi_req_fifo.sv
design/slow_memory.sv
design/ext_harness_top.sv
dv/tb_ext_harness.sv

//--- run.sh
#!/bin/sh
# Build and run the harness testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_ext_harness -Mdir "$OBJ" -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_ext_harness" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "Simulation PASSED"
exit 0
